/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// datapath and address width
`define XLEN 32

// instruction instance tag width
`define IID_W 8

// data RAM depth in 32-bit words
// word index is addr[.. :2], upper address bits ignored
`define DMEM_WORDS 256

// cycles from load acceptance to response pulse, at least 1
`define DMEM_READ_LATENCY 3

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

    typedef logic [`XLEN-1:0]  uint_x;
    typedef logic [31:0]       inst_pc_t;
    typedef logic [31:0]       inst_t;
    typedef logic [`IID_W-1:0] inst_id_t;

    // memory operation of an instruction
    typedef enum logic [1:0] {
        MEN_X,  // no access
        MEN_S,  // store
        MEN_LS, // signed load
        MEN_LU  // unsigned load
    } mem_sel_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef struct packed {
        mem_sel_e  mem_wen;
        mem_size_e mem_size;
    } ctrl_t;

    // bundle from execute
    typedef struct packed {
        logic     valid;
        inst_pc_t pc;
        inst_t    inst;
        inst_id_t inst_id;
        ctrl_t    ctrl;
        uint_x    alu_out;
        uint_x    csr_rdata;
        uint_x    rs2_data;
    } mem_in_t;

    // bundle to write-back
    typedef struct packed {
        logic     valid;
        inst_pc_t pc;
        inst_t    inst;
        inst_id_t inst_id;
        ctrl_t    ctrl;
        uint_x    alu_out;
        uint_x    mem_rdata;
        uint_x    csr_rdata;
    } wb_out_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        uint_x     addr;
        uint_x     wdata; // unshifted, lanes picked by the memory unit
        mem_size_e size;
    } d_request_t;

    typedef struct packed {
        logic  ready; // low while a load is pending
        logic  valid; // one-cycle load completion
        uint_x rdata;
    } d_response_t;

endpackage

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module memory_stage (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire mem_pkg::mem_in_t     mem_in,
    output mem_pkg::wb_out_t          wb_out,
    output logic                      stall,
    output mem_pkg::d_request_t       dreq,
    input  wire mem_pkg::d_response_t dresp
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_VALID
    } state_e;

    state_e   state;
    logic     is_cmd_executed; // access of saved_inst_id already done
    inst_id_t saved_inst_id;
    logic     may_start;
    mem_sel_e mem_op;
    logic     is_mem;
    logic     is_store;
    uint_x    saved_mem_rdata;

    // lb/lbu/lh/lhu/lw extension of lane-aligned load data
    function automatic uint_x extend_load(
        input mem_sel_e  sel,
        input mem_size_e size,
        input uint_x     raw
    );
        uint_x res;
        logic  sgn;
        sgn = (sel == MEN_LS);
        case (size)
            SIZE_B:  res = {{(`XLEN-8){sgn & raw[7]}}, raw[7:0]};
            SIZE_H:  res = {{(`XLEN-16){sgn & raw[15]}}, raw[15:0]};
            default: res = raw;
        endcase
        if (sel != MEN_LS && sel != MEN_LU) begin
            res = '0; // no load, nothing to report
        end
        return res;
    endfunction

    // a held instruction must not be issued a second time
    assign may_start = !is_cmd_executed || (saved_inst_id != mem_in.inst_id);

    assign mem_op   = mem_in.valid ? mem_in.ctrl.mem_wen : MEN_X;
    assign is_mem   = (mem_op != MEN_X);
    assign is_store = (mem_op == MEN_S);

    // rises combinationally as soon as a fresh access shows up
    assign stall = (state != IDLE) || (is_mem && may_start);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= IDLE;
            is_cmd_executed <= 1'b0;
            saved_inst_id   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (is_mem && may_start) begin
                        state           <= WAIT_READY;
                        saved_inst_id   <= mem_in.inst_id;
                        is_cmd_executed <= 1'b0;
                    end
                end
                WAIT_READY: begin
                    if (!is_mem) begin
                        state <= IDLE; // input dropped before issue
                    end else if (dresp.ready) begin
                        if (is_store) begin
                            state           <= IDLE; // store done at transfer
                            is_cmd_executed <= 1'b1;
                        end else begin
                            state <= WAIT_VALID;
                        end
                    end
                end
                WAIT_VALID: begin
                    if (dresp.valid) begin
                        state           <= IDLE;
                        is_cmd_executed <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // response data only valid during the pulse
    always_ff @(posedge clk) begin
        if (state == WAIT_VALID && dresp.valid) begin
            saved_mem_rdata <= dresp.rdata;
        end
    end

    always_comb begin
        dreq       = '0;
        dreq.valid = (state == WAIT_READY) && is_mem;
        dreq.wen   = is_store;
        dreq.addr  = mem_in.alu_out;
        dreq.wdata = mem_in.rs2_data;
        dreq.size  = mem_in.ctrl.mem_size;
    end

    // everything except the load data passes straight through
    always_comb begin
        wb_out           = '0;
        wb_out.valid     = mem_in.valid;
        wb_out.pc        = mem_in.pc;
        wb_out.inst      = mem_in.inst;
        wb_out.inst_id   = mem_in.inst_id;
        wb_out.ctrl      = mem_in.ctrl;
        wb_out.alu_out   = mem_in.alu_out;
        wb_out.csr_rdata = mem_in.csr_rdata;
        wb_out.mem_rdata = extend_load(mem_in.ctrl.mem_wen, mem_in.ctrl.mem_size,
                                       saved_mem_rdata);
    end

endmodule

`default_nettype wire

/* data_memory_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module data_memory_unit (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire mem_pkg::d_request_t dreq,
    output mem_pkg::d_response_t     dresp
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int CNT_W = $clog2(`DMEM_READ_LATENCY + 1);

    uint_x            mem [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [1:0]       lane;        // byte offset inside the word
    logic [3:0]       byte_en;
    uint_x            wdata_lane;  // store data moved onto its lanes
    logic             accept;
    logic             load_accept;
    logic             busy;        // load pending
    logic [CNT_W-1:0] cnt;
    uint_x            rd_word;
    logic [1:0]       rd_lane;

    assign idx         = dreq.addr[IDX_W+1:2];
    assign lane        = dreq.addr[1:0];
    assign accept      = dreq.valid && dresp.ready;
    assign load_accept = accept && !dreq.wen;
    assign wdata_lane  = dreq.wdata << {lane, 3'b000};

    always_comb begin
        case (dreq.size)
            SIZE_B:  byte_en = 4'b0001 << lane;
            SIZE_H:  byte_en = 4'b0011 << lane;
            default: byte_en = 4'b1111;
        endcase
    end

    // byte-lane merge, written on the accepting edge
    always_ff @(posedge clk) begin
        if (accept && dreq.wen) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[idx][8*i +: 8] <= wdata_lane[8*i +: 8];
                end
            end
        end
    end

    // word is sampled at acceptance, returned later
    always_ff @(posedge clk) begin
        if (load_accept) begin
            rd_word <= mem[idx];
            rd_lane <= lane;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (load_accept) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`DMEM_READ_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0; // pulse cycle just ended
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_comb begin
        dresp       = '0;
        dresp.ready = !busy;
        dresp.valid = busy && (cnt == '0);
        // addressed byte or half lands in the low bits
        dresp.rdata = rd_word >> {rd_lane, 3'b000};
    end

endmodule

`default_nettype wire

/* mem_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire mem_pkg::mem_in_t mem_in,
    output mem_pkg::wb_out_t      wb_out,
    output logic                  stall
);
    import mem_pkg::*;

    d_request_t  dreq;  // stage to memory unit
    d_response_t dresp; // memory unit back to stage

    memory_stage i_memory_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .mem_in (mem_in),
        .wb_out (wb_out),
        .stall  (stall),
        .dreq   (dreq),
        .dresp  (dresp)
    );

    data_memory_unit i_data_memory_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .dreq   (dreq),
        .dresp  (dresp)
    );

endmodule

`default_nettype wire

/* tb_mem_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int WAIT_LIMIT  = `DMEM_READ_LATENCY + 6; // cycles allowed per access
    localparam int N_ACCESSES  = 80;
    localparam int CYCLE_LIMIT = N_ACCESSES * (`DMEM_READ_LATENCY + 6) + 100;
    localparam int BYTES       = `DMEM_WORDS * 4;

    logic        clk = 1'b0;
    logic        arst_n;
    mem_in_t     mem_in;
    wb_out_t     wb_out;
    logic        stall;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] rng = 32'h9e7a5f31;
    inst_id_t    next_id = '0;
    logic [7:0]  ref_mem [BYTES];   // reference memory, byte addressed
    bit          ref_known [BYTES];
    int          known_words [$];   // fully written words, safe to load
    mem_in_t     last_bundle;

    mem_subsystem i_mem_subsystem (
        .clk    (clk),
        .arst_n (arst_n),
        .mem_in (mem_in),
        .wb_out (wb_out),
        .stall  (stall)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic check_word(input string name, input uint_x exp, input uint_x act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_wb(input wb_out_t exp, input wb_out_t act);
        check_level("wb_out.valid", exp.valid, act.valid);
        check_word("wb_out.pc", exp.pc, act.pc);
        check_word("wb_out.inst", exp.inst, act.inst);
        check_word("wb_out.inst_id", uint_x'(exp.inst_id), uint_x'(act.inst_id));
        check_word("wb_out.ctrl", uint_x'(exp.ctrl), uint_x'(act.ctrl));
        check_word("wb_out.alu_out", exp.alu_out, act.alu_out);
        check_word("wb_out.mem_rdata", exp.mem_rdata, act.mem_rdata);
        check_word("wb_out.csr_rdata", exp.csr_rdata, act.csr_rdata);
    endtask

    // lb/lbu/lh/lhu/lw straight from the byte model
    function automatic uint_x ref_load(input uint_x addr, input mem_sel_e sel,
                                       input mem_size_e size);
        int   a;
        logic sgn;
        a   = addr % BYTES;
        sgn = (sel == MEN_LS);
        case (size)
            SIZE_B:  return {{(`XLEN-8){sgn & ref_mem[a][7]}}, ref_mem[a]};
            SIZE_H:  return {{(`XLEN-16){sgn & ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    function automatic void ref_store(input uint_x addr, input mem_size_e size,
                                      input uint_x data);
        int a;
        int n;
        int w;
        bit was_full;
        a        = addr % BYTES;
        w        = a / 4;
        n        = (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
        was_full = ref_known[4*w] & ref_known[4*w+1] & ref_known[4*w+2] & ref_known[4*w+3];
        for (int i = 0; i < n; i++) begin
            ref_mem[a+i]   = data[8*i +: 8];
            ref_known[a+i] = 1'b1;
        end
        if (!was_full && (ref_known[4*w] & ref_known[4*w+1] & ref_known[4*w+2]
                          & ref_known[4*w+3])) begin
            known_words.push_back(w);
        end
    endfunction

    function automatic mem_in_t make_bundle(input mem_sel_e sel, input mem_size_e size,
                                            input uint_x addr, input uint_x data);
        mem_in_t b;
        next_id++;                     // every new instruction gets its own tag
        b.valid     = 1'b1;
        b.pc        = next_rand();
        b.inst      = next_rand();
        b.inst_id   = next_id;
        b.ctrl      = '{mem_wen: sel, mem_size: size};
        b.alu_out   = addr;
        b.csr_rdata = next_rand();
        b.rs2_data  = data;
        return b;
    endfunction

    function automatic wb_out_t expect_wb(input mem_in_t b, input uint_x rdata);
        wb_out_t w;
        w.valid     = b.valid;
        w.pc        = b.pc;
        w.inst      = b.inst;
        w.inst_id   = b.inst_id;
        w.ctrl      = b.ctrl;
        w.alu_out   = b.alu_out;
        w.mem_rdata = rdata;
        w.csr_rdata = b.csr_rdata;
        return w;
    endfunction

    // drive one memory instruction and hold it until stall drops
    task automatic issue(input mem_in_t b);
        int waited;
        last_bundle = b;
        @(posedge clk);
        mem_in <= b;
        @(negedge clk);
        check_level("stall at issue", 1'b1, stall);
        waited = 0;
        while (stall !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall !== 1'b0) begin
            errors++;
            $display("access with inst_id %0d never completed, stall still high after %0d cycles",
                     b.inst_id, waited);
        end
    endtask

    task automatic do_store(input uint_x addr, input mem_size_e size, input uint_x data);
        mem_in_t b;
        b = make_bundle(MEN_S, size, addr, data);
        issue(b);
        check_wb(expect_wb(b, '0), wb_out);
        ref_store(addr, size, data);
    endtask

    task automatic do_load(input uint_x addr, input mem_sel_e sel, input mem_size_e size);
        mem_in_t b;
        b = make_bundle(sel, size, addr, next_rand());
        issue(b);
        check_wb(expect_wb(b, ref_load(addr, sel, size)), wb_out);
    endtask

    task automatic pass_through(input mem_in_t b);
        @(posedge clk);
        mem_in <= b;
        @(negedge clk);
        check_level("stall", 1'b0, stall); // no access, no hold
        check_wb(expect_wb(b, '0), wb_out);
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_word_rw();
        int    e0;
        uint_x d;
        e0 = errors;
        d  = next_rand();
        do_store(32'h100, SIZE_W, d);
        do_load(32'h100, MEN_LS, SIZE_W);
        check_word("lw data", d, wb_out.mem_rdata);
        report("word store/load", e0);
    endtask

    task automatic test_lanes();
        int    e0;
        uint_x d;
        e0 = errors;
        do_store(32'h40, SIZE_W, next_rand());
        for (int lane = 0; lane < 4; lane++) begin
            d    = next_rand();
            d[7] = lane[0];             // odd lanes negative
            do_store(32'h40 + lane, SIZE_B, d);
            do_load(32'h40 + lane, MEN_LS, SIZE_B);
            do_load(32'h40 + lane, MEN_LU, SIZE_B);
            do_load(32'h40, MEN_LU, SIZE_W); // neighbours untouched
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            d     = next_rand();
            d[15] = lane[1];
            do_store(32'h40 + lane, SIZE_H, d);
            do_load(32'h40 + lane, MEN_LS, SIZE_H);
            do_load(32'h40 + lane, MEN_LU, SIZE_H);
            do_load(32'h40, MEN_LU, SIZE_W);
        end
        report("byte/half lanes", e0);
    endtask

    task automatic test_non_mem();
        int      e0;
        mem_in_t b;
        e0 = errors;
        pass_through(make_bundle(MEN_X, SIZE_W, next_rand(), next_rand()));
        do_store(32'h80, SIZE_W, next_rand());
        b       = make_bundle(MEN_S, SIZE_W, 32'h80, next_rand());
        b.valid = 1'b0;                 // invalid store must leave memory alone
        pass_through(b);
        do_load(32'h80, MEN_LU, SIZE_W);
        report("non-memory pass-through", e0);
    endtask

    task automatic test_held_id();
        int      e0;
        uint_x   d;
        mem_in_t held;
        e0 = errors;
        d  = next_rand();
        do_store(32'hc0, SIZE_W, d);
        held          = last_bundle;
        held.rs2_data = ~d;
        @(posedge clk);
        mem_in <= held;
        repeat (3) begin
            @(negedge clk);
            check_level("stall with held inst_id", 1'b0, stall);
        end
        do_load(32'hc0, MEN_LU, SIZE_W);
        check_word("mem_rdata after held store", d, wb_out.mem_rdata);
        next_id++;
        held.inst_id = next_id;         // same store, fresh tag
        issue(held);
        ref_store(32'hc0, SIZE_W, ~d);
        do_load(32'hc0, MEN_LU, SIZE_W);
        check_word("mem_rdata after new store", ~d, wb_out.mem_rdata);
        report("held inst_id", e0);
    endtask

    task automatic test_random(input int count);
        int          e0;
        logic [31:0] r;
        uint_x       addr;
        mem_size_e   size;
        e0 = errors;
        for (int n = 0; n < count; n++) begin
            r    = next_rand();
            addr = next_rand() % BYTES;
            size = (r[3:2] == 2'd0) ? SIZE_B : (r[3:2] == 2'd1) ? SIZE_H : SIZE_W;
            if (r[1:0] >= 2'd2 && known_words.size() > 0) begin
                addr = known_words[next_rand() % known_words.size()] * 4 + addr[1:0];
            end
            if (size == SIZE_H) begin
                addr[0] = 1'b0;
            end
            if (size == SIZE_W) begin
                addr[1:0] = 2'b00;
            end
            if (r[1:0] == 2'd0) begin
                pass_through(make_bundle(MEN_X, size, addr, next_rand()));
            end else if (r[1:0] == 2'd1 || known_words.size() == 0) begin
                do_store(addr, size, next_rand());
            end else begin
                do_load(addr, r[4] ? MEN_LS : MEN_LU, size);
            end
        end
        report("random sequence", e0);
    endtask

    initial begin
        mem_in = '0;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_word_rw();
        test_lanes();
        test_non_mem();
        test_held_id();
        test_random(40);
        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
mem_pkg.sv
memory_stage.sv
data_memory_unit.sv
mem_subsystem.sv
tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

export_include_dirs:
  - .

sources:
  - files:
      - mem_pkg.sv
      - memory_stage.sv
      - data_memory_unit.sv
      - mem_subsystem.sv
  - target: test
    files:
      - tb_mem_subsystem.sv
